//--- core_tests.txt
# name pc instr rd we wdata illegal
# pc, instr and wdata in hex; rd, we and illegal in decimal
addi_x1_5           00000000 00500093  1 1 00000005 0
addi_x2_neg3        00000004 ffd00113  2 1 fffffffd 0
lui_x3              00000008 123451b7  3 1 12345000 0
ori_x4              0000000c 0f006213  4 1 000000f0 0
add_fwd             00000010 002082b3  5 1 00000002 0
sub_fwd             00000014 40128333  6 1 fffffffd 0
slt_fwd             00000018 001323b3  7 1 00000001 0
xor_x8              0000001c 0041c433  8 1 123450f0 0
and_fwd             00000020 002474b3  9 1 123450f0 0
or_fwd              00000024 0074e533 10 1 123450f1 0
addi_to_x0          00000028 00708013  0 0 0000000c 0
add_x0_x0           0000002c 000005b3 11 1 00000000 0
addi_x12_max        00000030 7ff00613 12 1 000007ff 0
illegal_mul         00000034 02208633 12 0 00000000 1
addi_after_illegal  00000038 00160693 13 1 00000800 0
illegal_sll         0000003c 00209733 14 0 00000000 1
illegal_slti        00000040 0010a793 15 0 00000000 1
illegal_zero        00000044 00000000  0 0 00000000 1
xori_not            00000048 fff54813 16 1 edcbaf0e 0
andi_low_byte       0000004c 0ff87893 17 1 0000000e 0
sub_negate          00000050 41100933 18 1 fffffff2 0
slt_neg_vs_0        00000054 000929b3 19 1 00000001 0
slt_0_vs_neg        00000058 01202a33 20 1 00000000 0
lui_top             0000005c fffffab7 21 1 fffff000 0
add_lui_imm         00000060 00ca8b33 22 1 fffff7ff 0
add_self            00000064 016b0bb3 23 1 ffffeffe 0
double_x1_a         00000068 001080b3  1 1 0000000a 0
double_x1_b         0000006c 001080b3  1 1 00000014 0
double_x1_c         00000070 001080b3  1 1 00000028 0

//--- project.f
+incdir+.
core_isa_pkg.sv
core_pipe_pkg.sv
fetch_queue.sv
decoder.sv
issue_scoreboard.sv
alu_pipe.sv
commit_stage.sv
core_top.sv
tb_clock.sv
tb_core.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_core -f project.f -o tb_core_sim
./obj_dir/tb_core_sim

//--- tb_core.sv
// core testbench that replays the test table through the instruction port and checks commits
`timescale 1ns/1ns
`include "core_params.svh"

module tb_core import core_pipe_pkg::*; ();

  localparam int unsigned wait_limit = 200;

  logic             clk;
  logic             rst_n;
  logic             instr_valid;
  fetch_entry_t     instr;
  logic             instr_credit;
  logic             commit_valid;
  commit_rec_t      commit;
  logic             commit_credit;
  logic [`XLEN-1:0] instret;

  logic [8*24-1:0]  name_q   [$];
  fetch_entry_t     entry_q  [$];
  commit_rec_t      expect_q [$];
  int unsigned      num_tests;
  int unsigned      commits_seen;
  int unsigned      credits_returned;

  tb_clock i_clock (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  core_top DUT (
    .clk_i           ( clk           ),
    .rst_ni          ( rst_n         ),
    .instr_valid_i   ( instr_valid   ),
    .instr_i         ( instr         ),
    .instr_credit_o  ( instr_credit  ),
    .commit_valid_o  ( commit_valid  ),
    .commit_o        ( commit        ),
    .commit_credit_i ( commit_credit ),
    .instret_o       ( instret       )
  );

  // --------------------------------------------------
  // reporting
  // --------------------------------------------------
  task automatic stop_with_failure();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input logic [8*24-1:0] test_name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] %0s %0s: expected %h, actual %h", test_name, what, expected, actual);
      stop_with_failure();
    end
  endtask

  // --------------------------------------------------
  // test table
  // --------------------------------------------------
  task automatic load_tests();
    int              fd;
    int              code;
    string           line;
    logic [8*24-1:0] name;
    logic [31:0]     pc, word, wdata;
    int unsigned     rd, we, illegal;
    fetch_entry_t    fe;
    commit_rec_t     cr;
    fd = $fopen("core_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open core_tests.txt");
      stop_with_failure();
    end
    while (!$feof(fd)) begin
      code = $fgets(line, fd);
      if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
        code = $sscanf(line, "%s %h %h %d %d %h %d", name, pc, word, rd, we, wdata, illegal);
        if (code != 7) begin
          $display("malformed line in core_tests.txt: %s", line);
          stop_with_failure();
        end
        fe.pc      = pc;
        fe.instr   = word;
        cr.pc      = pc;
        cr.rd      = 5'(rd);
        cr.wdata   = wdata;
        cr.we      = (we != 0);
        cr.illegal = (illegal != 0);
        name_q.push_back(name);
        entry_q.push_back(fe);
        expect_q.push_back(cr);
      end
    end
    $fclose(fd);
    num_tests = entry_q.size();
  endtask

  // --------------------------------------------------
  // instruction sender spends one credit per beat
  // --------------------------------------------------
  task automatic send_all();
    int unsigned credits;
    int unsigned idx;
    int unsigned idle;
    credits = `FETCH_DEPTH;
    idx     = 0;
    idle    = 0;
    while (idx < num_tests) begin
      @(posedge clk);
      #1;
      if (instr_credit) begin
        credits++;
      end
      if (credits > `FETCH_DEPTH) begin
        $display("instruction port: more credits returned than queue entries");
        stop_with_failure();
      end
      if (credits > 0) begin
        instr_valid = 1'b1;
        instr       = entry_q[idx];
        credits--;
        idx++;
        idle = 0;
      end else begin
        instr_valid = 1'b0;
        idle++;
        if (idle > wait_limit) begin
          $display("timeout: no instruction credit came back for %0d cycles", wait_limit);
          stop_with_failure();
        end
      end
    end
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
  endtask

  // --------------------------------------------------
  // commit receiver with random credit stalls
  // --------------------------------------------------
  task automatic receive_all();
    int unsigned owed;
    int unsigned stall;
    int unsigned idle;
    commit_rec_t exp_rec;
    owed  = 0;
    stall = 0;
    idle  = 0;
    while (commits_seen < num_tests) begin
      @(posedge clk);
      #1;
      commit_credit = 1'b0;
      if (commit_valid) begin
        if (commits_seen >= `COMMIT_CREDITS + credits_returned) begin
          $display("commit port: a commit arrived without a granted credit");
          stop_with_failure();
        end
        exp_rec = expect_q[commits_seen];
        check_value(name_q[commits_seen], "pc", exp_rec.pc, commit.pc);
        check_value(name_q[commits_seen], "rd", 32'(exp_rec.rd), 32'(commit.rd));
        check_value(name_q[commits_seen], "we", 32'(exp_rec.we), 32'(commit.we));
        check_value(name_q[commits_seen], "illegal", 32'(exp_rec.illegal),
                    32'(commit.illegal));
        // wdata only matters when a register is written
        if (exp_rec.we) begin
          check_value(name_q[commits_seen], "wdata", exp_rec.wdata, commit.wdata);
        end
        commits_seen++;
        owed++;
        idle = 0;
      end else begin
        idle++;
        if (idle > wait_limit) begin
          $display("timeout: no commit seen for %0d cycles", wait_limit);
          stop_with_failure();
        end
      end
      if (stall > 0) begin
        stall--;
      end else if ($urandom % 8 == 0) begin
        stall = $urandom % 12;
      end else if (owed > 0) begin
        commit_credit = 1'b1;
        owed--;
        credits_returned++;
      end
    end
    @(posedge clk);
    #1;
    commit_credit = 1'b0;
  endtask

  initial begin
    int unsigned seed;
    int unsigned waited;
    seed = 32'hb80a_f11f;
    void'($urandom(seed));
    instr_valid      = 1'b0;
    instr            = '0;
    commit_credit    = 1'b0;
    commits_seen     = 0;
    credits_returned = 0;
    num_tests        = 0;
    load_tests();

    waited = 0;
    while (!rst_n) begin
      @(posedge clk);
      waited++;
      if (waited > wait_limit) begin
        $display("timeout: reset was never released");
        stop_with_failure();
      end
    end
    #1;
    check_value("reset", "instr_credit", 32'd0, 32'(instr_credit));
    check_value("reset", "commit_valid", 32'd0, 32'(commit_valid));

    fork
      send_all();
      receive_all();
    join

    check_value("instret", "count", num_tests, instret);
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      #1;
      if (commit_valid) begin
        $display("commit port: extra commit after the last test");
        stop_with_failure();
      end
    end

    if (num_tests != 0 && commits_seen == num_tests) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("no tests were read from core_tests.txt");
      stop_with_failure();
    end
  end

endmodule

//--- tb_clock.sv
// testbench clock and reset generator, 10 ns period, reset low for four cycles
`timescale 1ns/1ns

module tb_clock (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  // release just after an edge so the async reset never races the clock
  initial begin
    rst_no = 1'b0;
    repeat (4) @(posedge clk_o);
    #1;
    rst_no = 1'b1;
  end

endmodule

//--- core_top.sv
// core top level: fetch queue, decoder, issue scoreboard, alu pipe and commit stage
`timescale 1ns/1ns
`include "core_params.svh"

module core_top import core_pipe_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             instr_valid_i,
  input  fetch_entry_t     instr_i,
  output logic             instr_credit_o,
  output logic             commit_valid_o,
  output commit_rec_t      commit_o,
  input  logic             commit_credit_i,
  output logic [`XLEN-1:0] instret_o
);

  // --------------------------------------------------
  // stage links
  // --------------------------------------------------
  logic         fetch_valid_fq_id;
  fetch_entry_t fetch_entry_fq_id;
  issue_entry_t issue_entry_id_issue;
  logic         issue_ready_issue_id;
  logic         alu_valid_issue_ex;
  alu_req_t     alu_req_issue_ex;
  logic         wb_valid_ex_issue;
  alu_wb_t      wb_ex_issue;
  logic         head_valid_issue_commit;
  commit_rec_t  head_issue_commit;
  logic         commit_ack_commit_issue;
  rf_write_t    rf_write_commit_issue;

  fetch_queue i_fetch_queue (
    .clk_i    ( clk_i                ),
    .rst_ni   ( rst_ni               ),
    .valid_i  ( instr_valid_i        ),
    .entry_i  ( instr_i              ),
    .credit_o ( instr_credit_o       ),
    .valid_o  ( fetch_valid_fq_id    ),
    .entry_o  ( fetch_entry_fq_id    ),
    .ready_i  ( issue_ready_issue_id )
  );

  decoder i_decoder (
    .entry_i ( fetch_entry_fq_id    ),
    .issue_o ( issue_entry_id_issue )
  );

  issue_scoreboard i_issue_scoreboard (
    .clk_i         ( clk_i                   ),
    .rst_ni        ( rst_ni                  ),
    .issue_valid_i ( fetch_valid_fq_id       ),
    .issue_i       ( issue_entry_id_issue    ),
    .issue_ready_o ( issue_ready_issue_id    ),
    .alu_valid_o   ( alu_valid_issue_ex      ),
    .alu_req_o     ( alu_req_issue_ex        ),
    .wb_valid_i    ( wb_valid_ex_issue       ),
    .wb_i          ( wb_ex_issue             ),
    .head_valid_o  ( head_valid_issue_commit ),
    .head_o        ( head_issue_commit       ),
    .commit_ack_i  ( commit_ack_commit_issue ),
    .rf_write_i    ( rf_write_commit_issue   )
  );

  alu_pipe i_alu_pipe (
    .clk_i   ( clk_i              ),
    .rst_ni  ( rst_ni             ),
    .valid_i ( alu_valid_issue_ex ),
    .req_i   ( alu_req_issue_ex   ),
    .valid_o ( wb_valid_ex_issue  ),
    .wb_o    ( wb_ex_issue        )
  );

  commit_stage i_commit_stage (
    .clk_i          ( clk_i                   ),
    .rst_ni         ( rst_ni                  ),
    .head_valid_i   ( head_valid_issue_commit ),
    .head_i         ( head_issue_commit       ),
    .commit_ack_o   ( commit_ack_commit_issue ),
    .rf_write_o     ( rf_write_commit_issue   ),
    .commit_valid_o ( commit_valid_o          ),
    .commit_o       ( commit_o                ),
    .credit_i       ( commit_credit_i         ),
    .instret_o      ( instret_o               )
  );

endmodule

//--- commit_stage.sv
// commit stage: in-order retirement, register write-back, credit sender, retire counter
`timescale 1ns/1ns
`include "core_params.svh"

module commit_stage import core_pipe_pkg::*; (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             head_valid_i,
  input  commit_rec_t      head_i,
  output logic             commit_ack_o,
  output rf_write_t        rf_write_o,
  output logic             commit_valid_o,
  output commit_rec_t      commit_o,
  input  logic             credit_i,
  output logic [`XLEN-1:0] instret_o
);

  localparam int unsigned cred_w = $clog2(`COMMIT_CREDITS + 1);

  logic [cred_w-1:0] credit_q;
  logic              retire, wr_ok, valid_q;
  commit_rec_t       rec_d, rec_q;
  logic [`XLEN-1:0]  instret_q;

  // x0 and illegal encodings never write
  assign retire = head_valid_i && (credit_q != '0);
  assign wr_ok  = head_i.we && !head_i.illegal && (head_i.rd != '0);

  assign commit_ack_o    = retire;
  assign rf_write_o.we   = retire && wr_ok;
  assign rf_write_o.addr = head_i.rd;
  assign rf_write_o.data = head_i.wdata;

  always_comb begin
    rec_d    = head_i;
    rec_d.we = wr_ok;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q  <= cred_w'(`COMMIT_CREDITS);
      valid_q   <= 1'b0;
      instret_q <= '0;
    end else begin
      credit_q  <= credit_q + cred_w'(credit_i) - cred_w'(retire);
      valid_q   <= retire;
      instret_q <= instret_q + `XLEN'(retire);
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire) begin
      rec_q <= rec_d;
    end
  end

  assign commit_valid_o = valid_q;
  assign commit_o       = rec_q;
  assign instret_o      = instret_q;

endmodule

//--- alu_pipe.sv
// two-stage integer alu, fixed latency of two cycles
`timescale 1ns/1ns
`include "core_params.svh"

module alu_pipe import core_isa_pkg::*, core_pipe_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     valid_i,
  input  alu_req_t req_i,
  output logic     valid_o,
  output alu_wb_t  wb_o
);

  logic [`XLEN-1:0] result;
  logic             s1_valid_q, s2_valid_q;
  alu_wb_t          s1_q, s2_q;

  always_comb begin
    case (req_i.op)
      ALU_ADD:    result = req_i.a + req_i.b;
      ALU_SUB:    result = req_i.a - req_i.b;
      ALU_AND:    result = req_i.a & req_i.b;
      ALU_OR:     result = req_i.a | req_i.b;
      ALU_XOR:    result = req_i.a ^ req_i.b;
      ALU_SLT:    result = {{(`XLEN-1){1'b0}}, $signed(req_i.a) < $signed(req_i.b)};
      ALU_PASS_B: result = req_i.b;
      default:    result = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_q.trans_id <= req_i.trans_id;
    s1_q.result   <= result;
    s2_q          <= s1_q;
  end

  assign valid_o = s2_valid_q;
  assign wb_o    = s2_q;

endmodule

//--- issue_scoreboard.sv
// issue scoreboard: register file, in-order slots, operand forwarding and alu issue
`timescale 1ns/1ns
`include "core_params.svh"

module issue_scoreboard import core_pipe_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         issue_valid_i,
  input  issue_entry_t issue_i,
  output logic         issue_ready_o,
  output logic         alu_valid_o,
  output alu_req_t     alu_req_o,
  input  logic         wb_valid_i,
  input  alu_wb_t      wb_i,
  output logic         head_valid_o,
  output commit_rec_t  head_o,
  input  logic         commit_ack_i,
  input  rf_write_t    rf_write_i
);

  localparam int unsigned cnt_w = $clog2(`SB_ENTRIES + 1);

  logic [`XLEN-1:0]       rf_q     [`NR_REGS];
  issue_entry_t           slot_q   [`SB_ENTRIES];
  logic [`XLEN-1:0]       result_q [`SB_ENTRIES];
  logic [`SB_ENTRIES-1:0] valid_q, issued_q, done_q, wr_slot;
  trans_id_t              head_q, tail_q, iss_q;
  logic [cnt_w-1:0]       cnt_q;

  issue_entry_t     iss_e;
  trans_id_t        older_cnt, slot_idx, idx1, idx2;
  logic             hit1, hit2, rdy1, rdy2, iss_go, alloc;
  logic [`XLEN-1:0] rf1, rf2, op1, op2;

  // --------------------------------------------------
  // operand lookup for the oldest unissued slot
  // --------------------------------------------------
  assign iss_e     = slot_q[iss_q];
  assign older_cnt = iss_q - head_q;

  always_comb begin
    for (int s = 0; s < `SB_ENTRIES; s++) begin
      wr_slot[s] = valid_q[s] && !slot_q[s].illegal && (slot_q[s].rd != '0);
    end
  end

  // scan oldest to youngest so the youngest producer wins
  always_comb begin
    hit1     = 1'b0;
    hit2     = 1'b0;
    idx1     = '0;
    idx2     = '0;
    slot_idx = head_q;
    for (int k = 0; k < `SB_ENTRIES; k++) begin
      slot_idx = head_q + trans_id_t'(k);
      if (k < int'(older_cnt) && wr_slot[slot_idx]) begin
        if (slot_q[slot_idx].rd == iss_e.rs1) begin
          hit1 = 1'b1;
          idx1 = slot_idx;
        end
        if (slot_q[slot_idx].rd == iss_e.rs2) begin
          hit2 = 1'b1;
          idx2 = slot_idx;
        end
      end
    end
  end

  assign rf1  = (iss_e.rs1 == '0) ? '0 : rf_q[iss_e.rs1];
  assign rf2  = (iss_e.rs2 == '0) ? '0 : rf_q[iss_e.rs2];
  assign op1  = hit1 ? result_q[idx1] : rf1;
  assign op2  = hit2 ? result_q[idx2] : rf2;
  assign rdy1 = !hit1 || done_q[idx1];
  assign rdy2 = !hit2 || done_q[idx2];

  // illegal slots pass the issue point without an alu request
  assign iss_go      = valid_q[iss_q] && !issued_q[iss_q] && (iss_e.illegal || (rdy1 && rdy2));
  assign alu_valid_o = iss_go && !iss_e.illegal;

  assign alu_req_o.a        = op1;
  assign alu_req_o.b        = iss_e.use_imm ? iss_e.imm : op2;
  assign alu_req_o.op       = iss_e.op;
  assign alu_req_o.trans_id = iss_q;

  assign issue_ready_o = (cnt_q != cnt_w'(`SB_ENTRIES));
  assign alloc         = issue_valid_i && issue_ready_o;

  assign head_valid_o   = valid_q[head_q] && issued_q[head_q] && done_q[head_q];
  assign head_o.pc      = slot_q[head_q].pc;
  assign head_o.rd      = slot_q[head_q].rd;
  assign head_o.wdata   = result_q[head_q];
  assign head_o.we      = !slot_q[head_q].illegal;
  assign head_o.illegal = slot_q[head_q].illegal;

  // --------------------------------------------------
  // slot state
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      issued_q <= '0;
      done_q   <= '0;
      head_q   <= '0;
      tail_q   <= '0;
      iss_q    <= '0;
      cnt_q    <= '0;
    end else begin
      if (alloc) begin
        valid_q[tail_q]  <= 1'b1;
        issued_q[tail_q] <= 1'b0;
        done_q[tail_q]   <= issue_i.illegal;
        tail_q           <= tail_q + 1'b1;
      end
      if (iss_go) begin
        issued_q[iss_q] <= 1'b1;
        iss_q           <= iss_q + 1'b1;
      end
      if (wb_valid_i) begin
        done_q[wb_i.trans_id] <= 1'b1;
      end
      if (commit_ack_i) begin
        valid_q[head_q] <= 1'b0;
        head_q          <= head_q + 1'b1;
      end
      cnt_q <= cnt_q + cnt_w'(alloc) - cnt_w'(commit_ack_i);
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc) begin
      slot_q[tail_q]   <= issue_i;
      result_q[tail_q] <= '0;
    end
    if (wb_valid_i) begin
      result_q[wb_i.trans_id] <= wb_i.result;
    end
    if (rf_write_i.we && rf_write_i.addr != '0) begin
      rf_q[rf_write_i.addr] <= rf_write_i.data;
    end
  end

endmodule

//--- decoder.sv
// decoder: maps an rv32i subset to alu operations, registers and immediates
`timescale 1ns/1ns

module decoder import core_isa_pkg::*, core_pipe_pkg::*; (
  input  fetch_entry_t entry_i,
  output issue_entry_t issue_o
);

  rtype_t     instr;
  logic [2:0] f3;

  assign instr = rtype_t'(entry_i.instr);
  assign f3    = instr.funct3;

  always_comb begin
    issue_o         = '0;
    issue_o.pc      = entry_i.pc;
    issue_o.rd      = instr.rd;
    issue_o.rs1     = instr.rs1;
    issue_o.rs2     = instr.rs2;
    issue_o.op      = ALU_ADD;
    issue_o.illegal = 1'b0;
    case (instr.opcode)
      OPCODE_OP: begin
        if (instr.funct7 == F7_BASE) begin
          case (f3)
            F3_ADD:  issue_o.op = ALU_ADD;
            F3_SLT:  issue_o.op = ALU_SLT;
            F3_XOR:  issue_o.op = ALU_XOR;
            F3_OR:   issue_o.op = ALU_OR;
            F3_AND:  issue_o.op = ALU_AND;
            default: issue_o.illegal = 1'b1;
          endcase
        end else if (instr.funct7 == F7_ALT && f3 == F3_ADD) begin
          issue_o.op = ALU_SUB;
        end else begin
          issue_o.illegal = 1'b1;
        end
      end
      OPCODE_OP_IMM: begin
        // rs2 field is immediate here, so no source dependency on it
        issue_o.rs2     = '0;
        issue_o.use_imm = 1'b1;
        issue_o.imm     = {{20{entry_i.instr[31]}}, entry_i.instr[31:20]};
        case (f3)
          F3_ADD:  issue_o.op = ALU_ADD;
          F3_XOR:  issue_o.op = ALU_XOR;
          F3_OR:   issue_o.op = ALU_OR;
          F3_AND:  issue_o.op = ALU_AND;
          default: issue_o.illegal = 1'b1;
        endcase
      end
      OPCODE_LUI: begin
        issue_o.rs1     = '0;
        issue_o.rs2     = '0;
        issue_o.use_imm = 1'b1;
        issue_o.imm     = {entry_i.instr[31:12], 12'b0};
        issue_o.op      = ALU_PASS_B;
      end
      default: issue_o.illegal = 1'b1;
    endcase
  end

endmodule

//--- fetch_queue.sv
// fetch queue: credit-based receiver holding incoming pc and instruction pairs
`timescale 1ns/1ns
`include "core_params.svh"

module fetch_queue import core_pipe_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         valid_i,
  input  fetch_entry_t entry_i,
  output logic         credit_o,
  output logic         valid_o,
  output fetch_entry_t entry_o,
  input  logic         ready_i
);

  localparam int unsigned ptr_w = $clog2(`FETCH_DEPTH);
  localparam int unsigned cnt_w = $clog2(`FETCH_DEPTH + 1);

  fetch_entry_t     mem_q [`FETCH_DEPTH];
  logic [ptr_w-1:0] wr_ptr_q, rd_ptr_q;
  logic [cnt_w-1:0] cnt_q;
  logic             credit_q;
  logic             pop;

  assign valid_o  = (cnt_q != '0);
  assign entry_o  = mem_q[rd_ptr_q];
  assign pop      = valid_o && ready_i;
  assign credit_o = credit_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
      credit_q <= 1'b0;
    end else begin
      // sender only writes while it holds a credit
      if (valid_i) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w'(`FETCH_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w'(`FETCH_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      cnt_q    <= cnt_q + cnt_w'(valid_i) - cnt_w'(pop);
      // one credit back per freed entry
      credit_q <= pop;
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      mem_q[wr_ptr_q] <= entry_i;
    end
  end

endmodule

//--- core_pipe_pkg.sv
// pipeline package: records passed between fetch, decode, issue, execute and commit
`include "core_params.svh"

package core_pipe_pkg;
  import core_isa_pkg::*;

  typedef logic [`TRANS_ID_BITS-1:0] trans_id_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [31:0]      instr;
  } fetch_entry_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    alu_op_e          op;
    reg_idx_t         rd;
    reg_idx_t         rs1;
    reg_idx_t         rs2;
    logic [`XLEN-1:0] imm;
    logic             use_imm;
    logic             illegal;
  } issue_entry_t;

  typedef struct packed {
    logic [`XLEN-1:0] a;
    logic [`XLEN-1:0] b;
    alu_op_e          op;
    trans_id_t        trans_id;
  } alu_req_t;

  typedef struct packed {
    trans_id_t        trans_id;
    logic [`XLEN-1:0] result;
  } alu_wb_t;

  typedef struct packed {
    logic [`XLEN-1:0] pc;
    reg_idx_t         rd;
    logic [`XLEN-1:0] wdata;
    logic             we;
    logic             illegal;
  } commit_rec_t;

  typedef struct packed {
    logic             we;
    reg_idx_t         addr;
    logic [`XLEN-1:0] data;
  } rf_write_t;

endpackage

//--- core_isa_pkg.sv
// isa package: rv32i encoding fields, major opcodes and alu operations
`include "core_params.svh"

package core_isa_pkg;

  typedef logic [$clog2(`NR_REGS)-1:0] reg_idx_t;

  typedef enum logic [6:0] {
    OPCODE_OP     = 7'b0110011,
    OPCODE_OP_IMM = 7'b0010011,
    OPCODE_LUI    = 7'b0110111
  } opcode_e;

  // r-type view; i-type and u-type reuse the upper bits as immediate
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } rtype_t;

  localparam logic [2:0] F3_ADD = 3'b000;
  localparam logic [2:0] F3_SLT = 3'b010;
  localparam logic [2:0] F3_XOR = 3'b100;
  localparam logic [2:0] F3_OR  = 3'b110;
  localparam logic [2:0] F3_AND = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;

  typedef enum logic [2:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
  } alu_op_e;

endpackage

//--- core_params.svh
// core parameters: data width, register count, queue and scoreboard depths, credits
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

`define XLEN           32
`define NR_REGS        32
// fetch queue depth, also the sender's initial credit count
`define FETCH_DEPTH    4
`define SB_ENTRIES     4
`define TRANS_ID_BITS  2
// credits held on the commit port after reset
`define COMMIT_CREDITS 2

`endif
